// File: filelist.f
+incdir+include
hw/fetch_pkg.sv
hw/md_stall_timer.sv
hw/instr_classify.sv
hw/apb_fetch_master.sv
hw/pc_sequencer.sv
hw/fetch_top.sv
bench/imem_apb_model.sv
bench/fetch_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --top-module fetch_tb -f filelist.f -o fetch_sim
	./obj_dir/fetch_sim > sim.log
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/fetch_tb.sv
`include "fetch_config.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int N_INSTR   = 18;  // accepted instructions up to the parking jal
    localparam int MAX_CYCLE = N_INSTR * (4 + `DIV_LATENCY + 8);
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    logic       clk;
    logic       rst_n;
    logic       instr_ready;
    logic [1:0] wait_sel;
    instr_t     prdata;
    logic       pready;
    logic       pslverr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    pc_t        paddr;
    instr_t     pwdata;
    logic       instr_valid;
    pc_t        instr_pc;
    instr_t     instr_word;
    logic       md_busy;

    instr_t      image [0:255];  // expected memory contents
    logic [15:0] lfsr;
    int          errors;
    int          accepted;
    int          cyc;
    int          valid_rise_cyc;
    int          md_min_gap;     // nonzero while a mul or div awaits the next fetch
    int          busy_left;      // cycles md_busy is still expected high
    logic        timed_out;
    logic        after_reset;
    logic        prev_psel;
    logic        prev_penable;
    logic        prev_pready;
    logic        prev_valid;
    logic        prev_ready;
    pc_t         exp_pc;
    pc_t         xfer_addr;
    pc_t         held_pc;
    instr_t      held_word;
    instr_t      exp_word;

    fetch_top u_fetch_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .instr_ready (instr_ready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr_word  (instr_word),
        .md_busy     (md_busy)
    );

    imem_apb_model u_imem (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .paddr    (paddr),
        .wait_sel (wait_sel),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic instr_t enc_jal(input logic [4:0] rd, input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic instr_t enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                       input int off);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic instr_t enc_md(input logic [2:0] f3, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [4:0] rd);
        return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [7:0] mem_index(input pc_t pc);
        pc_t off;
        off = pc - `RESET_PC;
        return off[9:2];
    endfunction

    // busy cycles expected after an instruction or 0 when not mul/div
    function automatic int md_latency(input instr_t w);
        if ((w[6:0] != 7'b0110011) || (w[31:25] != 7'b0000001))
            return 0;
        return w[14] ? `DIV_LATENCY : `MUL_LATENCY;  // funct3 4..7 is div/rem
    endfunction

    function automatic pc_t next_pc_ref(input pc_t pc, input instr_t w);
        pc_t imm_j;
        pc_t imm_i;
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        imm_i = {{20{w[31]}}, w[31:20]};
        if (w[6:0] == 7'b1101111)
            next_pc_ref = pc + imm_j;
        else if (w[6:0] == 7'b1100111)
            next_pc_ref = imm_i & ~pc_t'(1);  // base is x0
        else
            next_pc_ref = pc + 32'd4;         // branches count as not taken
    endfunction

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_gap(input string name, input int min_gap, input int act);
        if (act < min_gap) begin
            errors++;
            $display("ERROR %0t %s: expected at least %0d, got %0d", $time, name, min_gap, act);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++)
            image[i] = enc_i(12'(i), 5'd0, 5'd0, OP_IMM);  // addi x0, x0, index
        image[0]  = enc_i(12'd5, 5'd0, 5'd1, OP_IMM);
        image[1]  = enc_i(12'd7, 5'd1, 5'd2, OP_IMM);
        image[2]  = enc_beq(5'd1, 5'd2, 16);              // falls through
        image[3]  = enc_md(3'b000, 5'd2, 5'd1, 5'd3);     // mul
        image[4]  = enc_jal(5'd0, 12);                    // skips two words
        image[7]  = enc_i(12'd1, 5'd0, 5'd4, OP_IMM);
        image[8]  = enc_md(3'b100, 5'd1, 5'd3, 5'd5);     // div
        image[9]  = enc_md(3'b111, 5'd2, 5'd3, 5'd6);     // remu
        image[10] = enc_i(12'h100, 5'd0, 5'd0, OP_JALR);  // to 0x100
        image[64] = enc_i(12'd3, 5'd0, 5'd7, OP_IMM);
        image[65] = enc_jal(5'd1, 12);
        image[66] = enc_md(3'b001, 5'd7, 5'd7, 5'd8);     // mulh
        image[67] = enc_jal(5'd0, 12);
        image[68] = enc_i(12'hfff, 5'd0, 5'd9, OP_IMM);
        image[69] = enc_jal(5'd0, -12);                   // back to 0x108
        image[70] = enc_i(12'h0c1, 5'd0, 5'd0, OP_JALR);  // odd target lands on 0xc0
        image[48] = enc_i(12'd2, 5'd9, 5'd9, OP_IMM);
        image[49] = enc_jal(5'd0, 0);                     // parks here
        for (int i = 0; i < 256; i++)
            u_imem.mem[i] = image[i];
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_ready = 1'b0;
        wait_sel    = 2'd0;
        lfsr        = 16'd19483;
        errors      = 0;
        accepted    = 0;
        cyc         = 0;
        md_min_gap  = 0;
        busy_left   = 0;
        timed_out   = 1'b0;
        after_reset = 1'b1;
        {prev_psel, prev_penable, prev_pready, prev_valid, prev_ready} = '0;
        exp_pc      = `RESET_PC;
        load_program();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait ((accepted == N_INSTR) || timed_out);
        @(negedge clk);
        $display("summary: %0d of %0d instructions accepted, %0d errors",
                 accepted, N_INSTR, errors);
        if ((errors == 0) && (accepted == N_INSTR))
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // random wait states and downstream stalls
    always @(negedge clk) begin
        logic b0;
        logic b1;
        logic b2;
        take_bit(b0);
        take_bit(b1);
        take_bit(b2);
        wait_sel    = {b1, b0};
        instr_ready = b2;
    end

    always @(posedge clk) begin
        if (!rst_n || after_reset) begin
            if (instr_valid || psel || penable) begin
                errors++;
                $display("%0t: instr_valid, psel or penable high around reset", $time);
            end
            after_reset = !rst_n;
        end else if (!timed_out && (accepted < N_INSTR)) begin
            cyc++;
            check_flag("md_busy", (busy_left > 0), md_busy);
            if (busy_left > 0)
                busy_left--;
            if (instr_valid && !prev_valid) begin
                valid_rise_cyc = cyc;
                busy_left      = md_latency(image[mem_index(exp_pc)]);  // timer starts here
            end
            if (psel && instr_valid) begin
                errors++;
                $display("%0t: APB transfer running while an instruction is offered", $time);
            end
            if (psel && pwrite) begin
                errors++;
                $display("%0t: fetch port issued a write", $time);
            end
            if (psel)
                check_word("pwdata", '0, pwdata);
            if (psel && !penable) begin  // setup
                if (prev_psel && !prev_penable) begin
                    errors++;
                    $display("%0t: setup phase lasted more than one cycle", $time);
                end
                check_pc("paddr", exp_pc, paddr);
                xfer_addr = paddr;
                if (md_min_gap > 0) begin
                    check_gap("mul/div fetch gap", md_min_gap, cyc - valid_rise_cyc - 1);
                    md_min_gap = 0;
                end
            end
            if (penable) begin
                if (!psel || !(prev_psel && (!prev_penable || !prev_pready))) begin
                    errors++;
                    $display("%0t: access phase not preceded by a setup cycle", $time);
                end
                check_pc("paddr", xfer_addr, paddr);
            end
            if (prev_valid && !prev_ready) begin
                if (!instr_valid) begin
                    errors++;
                    $display("%0t: instr_valid dropped before the handshake", $time);
                end
                check_pc("instr_pc", held_pc, instr_pc);
                check_word("instr_word", held_word, instr_word);
            end
            held_pc   = instr_pc;
            held_word = instr_word;
            if (instr_valid && instr_ready) begin
                exp_word = image[mem_index(exp_pc)];
                check_pc("instr_pc", exp_pc, instr_pc);
                check_word("instr_word", exp_word, instr_word);
                md_min_gap = md_latency(exp_word);
                exp_pc     = next_pc_ref(exp_pc, exp_word);
                accepted++;
            end
            prev_psel    = psel;
            prev_penable = penable;
            prev_pready  = pready;
            prev_valid   = instr_valid;
            prev_ready   = instr_ready;
            if ((cyc >= MAX_CYCLE) && (accepted < N_INSTR)) begin
                timed_out = 1'b1;
                errors++;
                $display("%0t: run timed out after %0d cycles with %0d of %0d accepted",
                         $time, cyc, accepted, N_INSTR);
            end
        end
    end

endmodule

// File: bench/imem_apb_model.sv
`include "fetch_config.svh"

module imem_apb_model
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  pc_t        paddr,
    input  logic [1:0] wait_sel,  // wait states for a transfer that is in setup
    output instr_t     prdata,
    output logic       pready,
    output logic       pslverr
);

    // filled by the testbench before reset is released
    instr_t     mem [0:255];
    pc_t        offset;
    logic [1:0] wait_cnt;

    assign offset = paddr - `RESET_PC;

    // only offset bits 9:2 decoded, so the array aliases every 1 KiB
    assign prdata  = mem[offset[9:2]];
    assign pready  = psel && penable && (wait_cnt == 2'd0);
    assign pslverr = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= 2'd0;
        end else if (psel && !penable) begin
            wait_cnt <= wait_sel;  // zero to three extra access cycles
        end else if (psel && penable && (wait_cnt != 2'd0)) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

// File: hw/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t prdata,
    input  logic   pready,
    input  logic   pslverr,
    input  logic   instr_ready,
    output logic   psel,
    output logic   penable,
    output logic   pwrite,
    output pc_t    paddr,
    output instr_t pwdata,
    output logic   instr_valid,
    output pc_t    instr_pc,
    output instr_t instr_word,
    output logic   md_busy
);

    logic         fetch_req;
    pc_t          fetch_addr;
    logic         fetch_done;
    instr_t       fetch_word;
    instr_class_t cls;
    pc_t          jal_target;
    pc_t          jalr_target;
    logic         md_start;
    logic         md_is_div;
    logic         md_done;

    pc_sequencer u_pc_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_done  (fetch_done),
        .fetch_word  (fetch_word),
        .cls         (cls),
        .jal_target  (jal_target),
        .jalr_target (jalr_target),
        .md_done     (md_done),
        .instr_ready (instr_ready),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .md_start    (md_start),
        .md_is_div   (md_is_div),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr_word  (instr_word)
    );

    apb_fetch_master u_apb_fetch_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .fetch_done (fetch_done),
        .fetch_word (fetch_word)
    );

    // classifies the word in flight, sequencer registers the result
    instr_classify u_instr_classify (
        .word        (fetch_word),
        .pc          (fetch_addr),
        .cls         (cls),
        .jal_target  (jal_target),
        .jalr_target (jalr_target)
    );

    md_stall_timer u_md_stall_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_start  (md_start),
        .md_is_div (md_is_div),
        .md_busy   (md_busy),
        .md_done   (md_done)
    );

endmodule

// File: hw/pc_sequencer.sv
`include "fetch_config.svh"

module pc_sequencer
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         fetch_done,
    input  instr_t       fetch_word,
    input  instr_class_t cls,
    input  pc_t          jal_target,
    input  pc_t          jalr_target,
    input  logic         md_done,
    input  logic         instr_ready,
    output logic         fetch_req,
    output pc_t          fetch_addr,
    output logic         md_start,
    output logic         md_is_div,
    output logic         instr_valid,
    output pc_t          instr_pc,
    output instr_t       instr_word
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_WAIT = 2'd1,
        S_HOLD = 2'd2,
        S_MD   = 2'd3
    } seq_state_t;

    seq_state_t   state;
    seq_state_t   state_nxt;
    pc_t          curr_pc;
    pc_t          pc_nxt;
    instr_class_t cls_q;
    pc_t          jal_q;
    pc_t          jalr_q;
    logic         hs;
    logic         capture;
    logic         new_is_md;
    logic         hold_is_md;
    logic         md_seen;
    logic         pc_load;

    assign hs         = instr_valid && instr_ready;
    assign capture    = (state == S_WAIT) && fetch_done;
    assign new_is_md  = (cls == CLS_MUL) || (cls == CLS_DIV);
    assign hold_is_md = (cls_q == CLS_MUL) || (cls_q == CLS_DIV);

    assign instr_valid = (state == S_HOLD);
    assign fetch_addr  = curr_pc;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (fetch_req) // first idle cycle after reset only arms the request
                    state_nxt = S_WAIT;
            end
            S_WAIT: begin
                if (fetch_done)
                    state_nxt = S_HOLD;
            end
            S_HOLD: begin
                if (hs) begin
                    // timer may already be finished while downstream stalled
                    if (!hold_is_md || md_seen || md_done)
                        state_nxt = S_IDLE;
                    else
                        state_nxt = S_MD;
                end
            end
            S_MD: begin
                if (md_done)
                    state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    // next fetch address from the class of the held instruction
    always_comb begin
        case (cls_q)
            CLS_JAL:  pc_nxt = jal_q;
            CLS_JALR: pc_nxt = jalr_q;
            default:  pc_nxt = instr_pc + `CPU_WIDTH'd4; // seq, branch, mul, div
        endcase
    end

    assign pc_load = (state != S_IDLE) && (state_nxt == S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            curr_pc   <= `RESET_PC;
            fetch_req <= 1'b0;
            md_start  <= 1'b0;
            md_is_div <= 1'b0;
            md_seen   <= 1'b0;
        end else begin
            state     <= state_nxt;
            fetch_req <= (state_nxt == S_IDLE); // one cycle pulse per idle visit
            md_start  <= capture && new_is_md;  // timer overlaps the downstream wait
            if (capture)
                md_is_div <= (cls == CLS_DIV);
            if (pc_load)
                curr_pc <= pc_nxt;
            // remember an early finish until the handshake
            if ((state == S_HOLD) && !hs)
                md_seen <= md_seen || md_done;
            else
                md_seen <= 1'b0;
        end
    end

    // output and decode payload, stable through HOLD
    always_ff @(posedge clk) begin
        if (capture) begin
            instr_pc   <= curr_pc;
            instr_word <= fetch_word;
            cls_q      <= cls;
            jal_q      <= jal_target;
            jalr_q     <= jalr_target;
        end
    end

endmodule

// File: hw/apb_fetch_master.sv
module apb_fetch_master
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   fetch_req,
    input  pc_t    fetch_addr,
    input  instr_t prdata,
    input  logic   pready,
    input  logic   pslverr,  // not acted on, word taken as returned
    output logic   psel,
    output logic   penable,
    output logic   pwrite,
    output pc_t    paddr,
    output instr_t pwdata,
    output logic   fetch_done,
    output instr_t fetch_word
);

    typedef enum logic [1:0] {
        A_IDLE   = 2'd0,
        A_SETUP  = 2'd1,
        A_ACCESS = 2'd2
    } apb_state_t;

    apb_state_t state;
    logic       xfer_end;

    assign xfer_end = (state == A_ACCESS) && pready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= A_IDLE;
        end else begin
            case (state)
                A_IDLE:   if (fetch_req) state <= A_SETUP;
                A_SETUP:  state <= A_ACCESS; // setup is always a single cycle
                A_ACCESS: if (pready) state <= A_IDLE;
                default:  state <= A_IDLE;
            endcase
        end
    end

    // address held from setup to the end of access
    always_ff @(posedge clk) begin
        if ((state == A_IDLE) && fetch_req)
            paddr <= fetch_addr;
    end

    assign psel    = (state != A_IDLE);
    assign penable = (state == A_ACCESS);
    assign pwrite  = 1'b0;          // read only port
    assign pwdata  = '0;

    assign fetch_done = xfer_end;   // same cycle as pready in access
    assign fetch_word = prdata;

endmodule

// File: hw/instr_classify.sv
`include "fetch_config.svh"

module instr_classify
    import fetch_pkg::*;
(
    input  instr_t       word,
    input  pc_t          pc,
    output instr_class_t cls,
    output pc_t          jal_target,
    output pc_t          jalr_target
);

    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    pc_t        imm_j;
    pc_t        imm_i;

    assign opcode = word[6:0];
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    always_comb begin
        cls = CLS_SEQ;
        case (opcode)
            OP_JAL:  cls = CLS_JAL;
            OP_JALR: cls = CLS_JALR;
            OP_REG: begin
                if (funct7 == F7_MULDIV)
                    cls = funct3[2] ? CLS_DIV : CLS_MUL; // div/rem live in funct3 4..7
            end
            default: cls = CLS_SEQ;
        endcase
    end

    // j immediate, scrambled as imm[20|10:1|11|19:12]
    assign imm_j = {{(`CPU_WIDTH-21){word[31]}},
                    word[31],
                    word[19:12],
                    word[20],
                    word[30:21],
                    1'b0};

    // i immediate, sign extended from bit 31
    assign imm_i = {{(`CPU_WIDTH-12){word[31]}}, word[31:20]};

    assign jal_target = pc + imm_j;

    // rs1 taken as x0 here, so the target is the immediate itself
    assign jalr_target = {imm_i[`CPU_WIDTH-1:1], 1'b0};

endmodule

// File: hw/md_stall_timer.sv
`include "fetch_config.svh"

module md_stall_timer
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic md_is_div,
    output logic md_busy,
    output logic md_done
);

    localparam logic [`MD_CNT_W-1:0] MUL_CYC = `MD_CNT_W'(`MUL_LATENCY);
    localparam logic [`MD_CNT_W-1:0] DIV_CYC = `MD_CNT_W'(`DIV_LATENCY);

    logic [`MD_CNT_W-1:0] cnt;
    logic [`MD_CNT_W-1:0] load_val;

    assign load_val = md_is_div ? DIV_CYC : MUL_CYC;

    // last busy cycle, lands latency cycles after the start pulse
    assign md_done = md_busy && (cnt == `MD_CNT_W'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_busy <= 1'b0;
            cnt     <= '0;
        end else if (md_start) begin
            md_busy <= 1'b1;
            cnt     <= load_val;
        end else if (md_busy) begin
            cnt <= cnt - `MD_CNT_W'd1;
            if (md_done)
                md_busy <= 1'b0;  // unit free again
        end
    end

endmodule

// File: hw/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    // fetch address, follows the core width
    typedef logic [`CPU_WIDTH-1:0] pc_t;

    // rv32 instruction word is always 32 bits
    typedef logic [31:0] instr_t;

    // coarse instruction classes seen by the front end
    // branches fall into seq, they are treated as not taken
    typedef enum logic [2:0] {
        CLS_SEQ  = 3'd0,  // anything that goes to pc+4
        CLS_JAL  = 3'd1,  // pc relative jump
        CLS_JALR = 3'd2,  // register jump, base taken as x0
        CLS_MUL  = 3'd3,  // mul, mulh, mulhsu, mulhu
        CLS_DIV  = 3'd4   // div, divu, rem, remu
    } instr_class_t;

endpackage

// File: include/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and data path width
`define CPU_WIDTH 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// busy cycles of the multicycle unit, counted from md_start
`define MUL_LATENCY 3
`define DIV_LATENCY 16

// wide enough to hold the larger of the two latencies
`define MD_CNT_W 5

`endif
